// File: design/axi_lite_config.svh
`ifndef AXI_LITE_CONFIG_SVH
`define AXI_LITE_CONFIG_SVH

// Byte address width of the write bus.
`define AXI_ADDR_W 8

// Data width; strobe width is this over 8.
`define AXI_DATA_W 32

// Registers in the slave bank.
`define REG_COUNT 16

`endif

// File: design/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

    // Master index, also the arbiter state.
    typedef enum logic [1:0] {
        MASTER_0,
        MASTER_1,
        MASTER_2
    } master_e;

    // Write response codes.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_e;

    // Write router phases.
    typedef enum logic [1:0] {
        ROUTE_IDLE,
        ROUTE_DATA,
        ROUTE_RESP
    } router_state_e;

endpackage

`default_nettype wire

// File: design/axi_lite_wr_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "axi_lite_config.svh"

interface axi_lite_wr_if
    import axi_lite_pkg::*;
();

    // Write address channel.
    logic                       awvalid;
    logic                       awready;
    logic [`AXI_ADDR_W-1:0]     awaddr;

    // Write data channel.
    logic                       wvalid;
    logic                       wready;
    logic [`AXI_DATA_W-1:0]     wdata;
    logic [`AXI_DATA_W/8-1:0]   wstrb;

    // Write response channel.
    logic                       bvalid;
    logic                       bready;
    resp_e                      bresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready,
        input  awready, wready, bvalid, bresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
        output awready, wready, bvalid, bresp
    );

endinterface

`default_nettype wire

// File: design/axi_arbiter_aw.sv
`default_nettype none
`timescale 1ns/1ps

module axi_arbiter_aw
    import axi_lite_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic [2:0] aw_valid,
    output logic [2:0] grant
);

    master_e state;
    master_e next_state;

    //------------------------------------------------------------
    // Sticky grant, then lowest other index.
    //------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            MASTER_0: begin
                if (aw_valid[0])
                    next_state = MASTER_0;
                else if (aw_valid[1])
                    next_state = MASTER_1;
                else if (aw_valid[2])
                    next_state = MASTER_2;
            end
            MASTER_1: begin
                if (aw_valid[1])
                    next_state = MASTER_1;
                else if (aw_valid[0])
                    next_state = MASTER_0;
                else if (aw_valid[2])
                    next_state = MASTER_2;
            end
            MASTER_2: begin
                if (aw_valid[2])
                    next_state = MASTER_2;
                else if (aw_valid[0])
                    next_state = MASTER_0;
                else if (aw_valid[1])
                    next_state = MASTER_1;
            end
            default: begin
                next_state = MASTER_0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni)
            state <= MASTER_0;
        else
            state <= next_state;
    end

    // One-hot decode, bit i for master i.
    always_comb begin
        case (state)
            MASTER_0: grant = 3'b001;
            MASTER_1: grant = 3'b010;
            MASTER_2: grant = 3'b100;
            default:  grant = 3'b000;
        endcase
    end

    a_grant_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot(grant)
    );

endmodule

`default_nettype wire

// File: design/axi_wr_router.sv
`default_nettype none
`timescale 1ns/1ps

`include "axi_lite_config.svh"

module axi_wr_router
    import axi_lite_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [2:0]                     grant,
    input  logic [2:0]                     m_awvalid,
    input  logic [2:0][`AXI_ADDR_W-1:0]    m_awaddr,
    output logic [2:0]                     m_awready,
    input  logic [2:0]                     m_wvalid,
    input  logic [2:0][`AXI_DATA_W-1:0]    m_wdata,
    input  logic [2:0][`AXI_DATA_W/8-1:0]  m_wstrb,
    output logic [2:0]                     m_wready,
    output logic [2:0]                     m_bvalid,
    output resp_e [2:0]                    m_bresp,
    input  logic [2:0]                     m_bready,
    axi_lite_wr_if.master                  slv
);

    router_state_e state;
    router_state_e next_state;
    master_e       grant_idx;
    master_e       lock_idx;
    master_e       cur_idx;
    logic          fwd_en;
    logic          aw_hs;

    always_comb begin
        case (grant)
            3'b010:  grant_idx = MASTER_1;
            3'b100:  grant_idx = MASTER_2;
            default: grant_idx = MASTER_0;
        endcase
    end

    // Grantee while idle, locked master afterwards.
    assign cur_idx = (state == ROUTE_IDLE) ? grant_idx : lock_idx;
    assign fwd_en  = (state == ROUTE_IDLE) ? m_awvalid[grant_idx] : (state == ROUTE_DATA);

    //------------------------------------------------------------
    // Slave side.
    //------------------------------------------------------------
    assign slv.awvalid = fwd_en && m_awvalid[cur_idx];
    assign slv.awaddr  = m_awaddr[cur_idx];
    assign slv.wvalid  = fwd_en && m_wvalid[cur_idx];
    assign slv.wdata   = m_wdata[cur_idx];
    assign slv.wstrb   = m_wstrb[cur_idx];
    assign slv.bready  = (state == ROUTE_RESP) && m_bready[lock_idx];

    assign aw_hs = slv.awvalid && slv.awready;

    //------------------------------------------------------------
    // Master side.
    //------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            m_awready[i] = fwd_en && (int'(cur_idx) == i) && slv.awready;
            m_wready[i]  = fwd_en && (int'(cur_idx) == i) && slv.wready;
            m_bvalid[i]  = (int'(lock_idx) == i) && slv.bvalid;
            m_bresp[i]   = (int'(lock_idx) == i) ? slv.bresp : RESP_OKAY;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ROUTE_IDLE: begin
                if (aw_hs)
                    next_state = ROUTE_RESP;
                else if (fwd_en && !slv.wvalid)
                    next_state = ROUTE_DATA;
            end
            ROUTE_DATA: begin
                if (aw_hs)
                    next_state = ROUTE_RESP;
            end
            ROUTE_RESP: begin
                if (slv.bvalid && slv.bready)
                    next_state = ROUTE_IDLE;
            end
            default: next_state = ROUTE_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state    <= ROUTE_IDLE;
            lock_idx <= MASTER_0;
        end else begin
            state <= next_state;
            // Tracks the grant until the router leaves idle.
            if (state == ROUTE_IDLE)
                lock_idx <= grant_idx;
        end
    end

    a_bvalid_in_resp: assert property (
        @(posedge clk_i) disable iff (!rst_ni) (m_bvalid != 3'b000) |-> (state == ROUTE_RESP)
    );

    a_awready_onehot0: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(m_awready)
    );

endmodule

`default_nettype wire

// File: design/axi_reg_slave.sv
`default_nettype none
`timescale 1ns/1ps

`include "axi_lite_config.svh"

module axi_reg_slave
    import axi_lite_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    axi_lite_wr_if.slave            bus,
    input  logic [`AXI_ADDR_W-1:0]  reg_raddr,
    output logic [`AXI_DATA_W-1:0]  reg_rdata
);

    localparam int IDX_W = $clog2(`REG_COUNT);

    logic [`AXI_DATA_W-1:0]  regs [`REG_COUNT];
    logic                    accept;
    logic [`AXI_ADDR_W-3:0]  wr_word;
    logic [`AXI_ADDR_W-3:0]  rd_word;
    logic                    wr_in_range;
    logic                    bvalid_q;
    resp_e                   bresp_q;

    // Word index, byte offset ignored.
    assign wr_word     = bus.awaddr[`AXI_ADDR_W-1:2];
    assign rd_word     = reg_raddr[`AXI_ADDR_W-1:2];
    assign wr_in_range = (wr_word < `REG_COUNT);

    // AW and W taken together while no response is pending.
    assign accept      = !bvalid_q && bus.awvalid && bus.wvalid;
    assign bus.awready = accept;
    assign bus.wready  = accept;
    assign bus.bvalid  = bvalid_q;
    assign bus.bresp   = bresp_q;

    //------------------------------------------------------------
    // Register bank.
    //------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int r = 0; r < `REG_COUNT; r++)
                regs[r] <= '0;
        end else if (accept && wr_in_range) begin
            for (int b = 0; b < `AXI_DATA_W/8; b++) begin
                if (bus.wstrb[b])
                    regs[wr_word[IDX_W-1:0]][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            bvalid_q <= 1'b0;
            bresp_q  <= RESP_OKAY;
        end else if (accept) begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end else if (bus.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    // Read port, out of range reads zero.
    always_ff @(posedge clk_i) begin
        if (rd_word < `REG_COUNT)
            reg_rdata <= regs[rd_word[IDX_W-1:0]];
        else
            reg_rdata <= '0;
    end

    a_b_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bresp)
    );

endmodule

`default_nettype wire

// File: design/axi_wr_interconnect_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "axi_lite_config.svh"

module axi_wr_interconnect_top
    import axi_lite_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [2:0]                     m_awvalid,
    input  logic [2:0][`AXI_ADDR_W-1:0]    m_awaddr,
    output logic [2:0]                     m_awready,
    input  logic [2:0]                     m_wvalid,
    input  logic [2:0][`AXI_DATA_W-1:0]    m_wdata,
    input  logic [2:0][`AXI_DATA_W/8-1:0]  m_wstrb,
    output logic [2:0]                     m_wready,
    output logic [2:0]                     m_bvalid,
    output resp_e [2:0]                    m_bresp,
    input  logic [2:0]                     m_bready,
    input  logic [`AXI_ADDR_W-1:0]         reg_raddr,
    output logic [`AXI_DATA_W-1:0]         reg_rdata
);

    logic [2:0] grant;

    axi_lite_wr_if slv_bus ();

    //------------------------------------------------------------
    // Arbiter, router, register slave.
    //------------------------------------------------------------
    axi_arbiter_aw u_arbiter (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .aw_valid (m_awvalid),
        .grant    (grant)
    );

    axi_wr_router u_router (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .grant     (grant),
        .m_awvalid (m_awvalid),
        .m_awaddr  (m_awaddr),
        .m_awready (m_awready),
        .m_wvalid  (m_wvalid),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .m_wready  (m_wready),
        .m_bvalid  (m_bvalid),
        .m_bresp   (m_bresp),
        .m_bready  (m_bready),
        .slv       (slv_bus.master)
    );

    axi_reg_slave u_slave (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .bus       (slv_bus.slave),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata)
    );

endmodule

`default_nettype wire

// File: verif/tb_axi_wr_interconnect.sv
`default_nettype none
`timescale 1ns/1ps

`include "axi_lite_config.svh"

module tb_axi_wr_interconnect
    import axi_lite_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 5;
    localparam int NUM_REGS   = 16;
    localparam int AW         = `AXI_ADDR_W;
    localparam int DW         = `AXI_DATA_W;

    logic                  clk_i;
    logic                  rst_ni;
    logic [2:0]            m_awvalid;
    logic [2:0][AW-1:0]    m_awaddr;
    logic [2:0]            m_awready;
    logic [2:0]            m_wvalid;
    logic [2:0][DW-1:0]    m_wdata;
    logic [2:0][DW/8-1:0]  m_wstrb;
    logic [2:0]            m_wready;
    logic [2:0]            m_bvalid;
    resp_e [2:0]           m_bresp;
    logic [2:0]            m_bready;
    logic [AW-1:0]         reg_raddr;
    logic [DW-1:0]         reg_rdata;

    logic [DW-1:0] model [NUM_REGS];
    int            test_errors;
    int            failed_tests;
    int            total_errors;
    int            done_order[$];

    axi_wr_interconnect_top DUT (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .m_awvalid (m_awvalid),
        .m_awaddr  (m_awaddr),
        .m_awready (m_awready),
        .m_wvalid  (m_wvalid),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .m_wready  (m_wready),
        .m_bvalid  (m_bvalid),
        .m_bresp   (m_bresp),
        .m_bready  (m_bready),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    //------------------------------------------------------------
    // Checking and scoreboard helpers.
    //------------------------------------------------------------
    task automatic check_value(input string name, input logic [DW-1:0] exp,
                               input logic [DW-1:0] act);
        assert (exp === act) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic model_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                               input logic [DW/8-1:0] strb);
        if (addr[AW-1:2] < NUM_REGS) begin
            for (int b = 0; b < DW/8; b++) begin
                if (strb[b])
                    model[addr[AW-1:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic finish_test(input string name);
        $display("%-16s %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
        if (test_errors != 0)
            failed_tests++;
        total_errors += test_errors;
        test_errors = 0;
    endtask

    //------------------------------------------------------------
    // Master driver and read port.
    //------------------------------------------------------------
    // A nonzero hold keeps bready low for that many cycles after bvalid.
    task automatic write_master(input int idx, input logic [AW-1:0] addr,
                                input logic [DW-1:0] data, input logic [DW/8-1:0] strb,
                                input int hold, output resp_e resp);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(negedge clk_i);
        m_awvalid[idx] = 1'b1;
        m_awaddr[idx]  = addr;
        m_wvalid[idx]  = 1'b1;
        m_wdata[idx]   = data;
        m_wstrb[idx]   = strb;
        m_bready[idx]  = (hold == 0);
        while (!(aw_done && w_done)) begin
            @(posedge clk_i);
            aw_done |= m_awvalid[idx] && m_awready[idx];
            w_done  |= m_wvalid[idx] && m_wready[idx];
            @(negedge clk_i);
            if (aw_done)
                m_awvalid[idx] = 1'b0;
            if (w_done)
                m_wvalid[idx] = 1'b0;
        end
        do @(posedge clk_i); while (!m_bvalid[idx]);
        resp = m_bresp[idx];
        if (hold > 0) begin
            repeat (hold) begin
                @(posedge clk_i);
                assert (m_bvalid[idx] && m_bresp[idx] == resp) else begin
                    $display("B channel of master %0d changed while bready was low", idx);
                    test_errors++;
                end
            end
            @(negedge clk_i);
            m_bready[idx] = 1'b1;
            @(posedge clk_i);
        end
        @(negedge clk_i);
        m_bready[idx] = 1'b0;
    endtask

    task automatic read_reg(input logic [AW-1:0] addr, output logic [DW-1:0] data);
        @(negedge clk_i);
        reg_raddr = addr;
        @(negedge clk_i);
        data = reg_rdata;
    endtask

    task automatic check_all_regs(input string name);
        logic [DW-1:0] data;
        for (int r = 0; r < NUM_REGS; r++) begin
            read_reg(AW'(r * 4), data);
            check_value(name, model[r], data);
        end
    endtask

    // Distinct write first, then the shared address.
    task automatic contend_writes(input int idx, input logic [AW-1:0] dist_addr,
                                  input logic [AW-1:0] shared_addr,
                                  input logic [DW-1:0] dist_data,
                                  input logic [DW-1:0] shared_data);
        resp_e resp;
        write_master(idx, dist_addr, dist_data, 4'hf, 0, resp);
        done_order.push_back(idx);
        check_value("contention", RESP_OKAY, resp);
        write_master(idx, shared_addr, shared_data, 4'hf, 0, resp);
        check_value("contention", RESP_OKAY, resp);
    endtask

    //------------------------------------------------------------
    // Directed tests.
    //------------------------------------------------------------
    task automatic test_reset_single();
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic [DW-1:0] rd;
        resp_e         resp;
        check_value("reset_single", '0, {m_bvalid, m_awready, m_wready});
        check_all_regs("reset_single");
        addr = AW'(($urandom % NUM_REGS) * 4);
        data = $urandom;
        write_master(1, addr, data, 4'hf, 0, resp);
        check_value("reset_single", RESP_OKAY, resp);
        model_write(addr, data, 4'hf);
        read_reg(addr, rd);
        check_value("reset_single", model[addr[AW-1:2]], rd);
        finish_test("reset_single");
    endtask

    task automatic test_byte_strobes();
        logic [AW-1:0]   addr;
        logic [DW-1:0]   data;
        logic [DW/8-1:0] strb;
        logic [DW-1:0]   rd;
        resp_e           resp;
        addr = AW'(($urandom % NUM_REGS) * 4);
        data = $urandom;
        strb = 4'($urandom_range(14, 1));
        write_master(0, addr, '1, 4'hf, 0, resp);
        model_write(addr, '1, 4'hf);
        write_master(0, addr, data, strb, 0, resp);
        check_value("byte_strobes", RESP_OKAY, resp);
        model_write(addr, data, strb);
        read_reg(addr, rd);
        check_value("byte_strobes", model[addr[AW-1:2]], rd);
        finish_test("byte_strobes");
    endtask

    task automatic test_out_of_range();
        logic [AW-1:0] addr;
        resp_e         resp;
        addr = AW'(64 + ($urandom % 48) * 4);
        write_master(0, addr, $urandom, 4'hf, 0, resp);
        check_value("out_of_range", RESP_SLVERR, resp);
        check_all_regs("out_of_range");
        finish_test("out_of_range");
    endtask

    task automatic test_contention();
        logic [DW-1:0] dd [3];
        logic [DW-1:0] sd [3];
        int            base;
        base = $urandom % (NUM_REGS - 3);
        for (int i = 0; i < 3; i++) begin
            dd[i] = $urandom;
            sd[i] = $urandom;
        end
        done_order.delete();
        fork
            contend_writes(0, AW'(base * 4), AW'((base + 3) * 4), dd[0], sd[0]);
            contend_writes(1, AW'((base + 1) * 4), AW'((base + 3) * 4), dd[1], sd[1]);
            contend_writes(2, AW'((base + 2) * 4), AW'((base + 3) * 4), dd[2], sd[2]);
        join
        for (int i = 0; i < 3; i++)
            check_value("contention", i, done_order[i]);
        for (int i = 0; i < 3; i++)
            model_write(AW'((base + i) * 4), dd[i], 4'hf);
        // Master 2 is granted last, so its shared write lands last.
        model_write(AW'((base + 3) * 4), sd[2], 4'hf);
        check_all_regs("contention");
        finish_test("contention");
    endtask

    task automatic test_back_pressure();
        logic [AW-1:0] a0;
        logic [AW-1:0] a2;
        logic [DW-1:0] d0;
        logic [DW-1:0] d2;
        resp_e         r0;
        resp_e         r2;
        int            hold;
        a0   = AW'(($urandom % 8) * 4);
        a2   = AW'((8 + $urandom % 8) * 4);
        d0   = $urandom;
        d2   = $urandom;
        hold = $urandom_range(10, 3);
        fork
            write_master(0, a0, d0, 4'hf, hold, r0);
            begin
                do @(posedge clk_i); while (!m_bvalid[0]);
                write_master(2, a2, d2, 4'hf, 0, r2);
            end
            do begin
                @(posedge clk_i);
                assert (!m_awready[2]) else begin
                    $display("Master 2 AW accepted before master 0 took its response");
                    test_errors++;
                end
            end while (!(m_bvalid[0] && m_bready[0]));
        join
        check_value("b_backpressure", RESP_OKAY, r0);
        check_value("b_backpressure", RESP_OKAY, r2);
        model_write(a0, d0, 4'hf);
        model_write(a2, d2, 4'hf);
        check_all_regs("b_backpressure");
        finish_test("b_backpressure");
    endtask

    //------------------------------------------------------------
    // Main sequence and watchdog.
    //------------------------------------------------------------
    initial begin
        int seed;
        seed         = $urandom(32'h5dfc2251);
        test_errors  = 0;
        failed_tests = 0;
        total_errors = 0;
        rst_ni       = 1'b0;
        m_awvalid    = '0;
        m_awaddr     = '0;
        m_wvalid     = '0;
        m_wdata      = '0;
        m_wstrb      = '0;
        m_bready     = '0;
        reg_raddr    = '0;
        for (int r = 0; r < NUM_REGS; r++)
            model[r] = '0;
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;
        test_reset_single();
        test_byte_strobes();
        test_out_of_range();
        test_contention();
        test_back_pressure();
        $display("Tests: %0d, failed: %0d, errors: %0d", NUM_TESTS, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((NUM_TESTS * 200 + 10) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/axi_lite_pkg.sv
design/axi_lite_wr_if.sv
design/axi_arbiter_aw.sv
design/axi_wr_router.sv
design/axi_reg_slave.sv
design/axi_wr_interconnect_top.sv
verif/tb_axi_wr_interconnect.sv
